// ==== common/vertex_job_consts.svh ====
`ifndef VERTEX_JOB_CONSTS_SVH
`define VERTEX_JOB_CONSTS_SVH

//////////////////////////////
// word and line geometry
//////////////////////////////
`define VERTEX_BITS     32   // one array word, also the vertex id
`define LINE_VERTICES   4    // vertices per cache line
`define LINE_BITS       128
`define LINE_BYTES      16   // address stride per chunk

//////////////////////////////
// bus and queue sizes
//////////////////////////////
`define ADDR_BITS       64
`define JOB_FIFO_DEPTH  8    // room for two lines
`define COUNT_BITS      4    // holds 0 .. LINE_VERTICES

`endif

// ==== common/vertex_job_pkg.sv ====
`include "vertex_job_consts.svh"

package vertex_job_pkg;

	// which of the three vertex arrays a read belongs to
	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} vertex_array_t;

	// travels out on the command and back on the response
	typedef struct packed {
		vertex_array_t              array;
		logic [`COUNT_BITS-1:0]     real_size;  // valid vertices in the line
	} read_tag_t;

	// one response line, raw or split into vertex words
	// words[0] is the lowest vertex, in the low bits
	typedef union packed {
		logic [`LINE_BITS-1:0]                          raw;
		logic [`LINE_VERTICES-1:0][`VERTEX_BITS-1:0]    words;
	} cacheline_t;

	typedef struct packed {
		logic [`VERTEX_BITS-1:0]    id;
		logic [`VERTEX_BITS-1:0]    in_degree;
		logic [`VERTEX_BITS-1:0]    out_degree;
		logic [`VERTEX_BITS-1:0]    edges_idx;
	} vertex_job_t;

endpackage

// ==== vertex_fetch/read_command_gen.sv ====
`timescale 1ns/1ps
`include "vertex_job_consts.svh"

module read_command_gen (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        start,
	input  logic [`VERTEX_BITS-1:0]     num_vertices,
	input  logic [`ADDR_BITS-1:0]       in_degree_base,
	input  logic [`ADDR_BITS-1:0]       out_degree_base,
	input  logic [`ADDR_BITS-1:0]       edges_idx_base,
	input  logic                        resp_valid,
	input  logic                        assembler_busy,
	input  logic                        almost_full,
	output logic                        cmd_valid,
	output logic [`ADDR_BITS-1:0]       cmd_addr,
	output logic [`COUNT_BITS+1:0]      cmd_size,
	output vertex_job_pkg::read_tag_t   cmd_tag
);

	typedef enum logic [2:0] {
		IDLE,
		SIZE,
		SEND_IN,
		SEND_OUT,
		SEND_EDGES
	} state_t;

	state_t state, next_state;

	logic [`ADDR_BITS-1:0]      in_base, out_base, edges_base;
	logic [`ADDR_BITS-1:0]      offset;       // chunk index times line bytes
	logic [`VERTEX_BITS-1:0]    remaining;
	logic [`COUNT_BITS-1:0]     real_size;
	logic [`COUNT_BITS-1:0]     chunk_size;
	logic [2:0]                 outstanding;
	logic                       chunk_ready;

	//////////////////////////////
	// chunk sequencing
	//////////////////////////////
	assign chunk_ready = (remaining != '0) && (outstanding == '0) &&
		!assembler_busy && !almost_full;

	// last chunk may be a partial line
	assign chunk_size = (remaining >= `VERTEX_BITS'(`LINE_VERTICES)) ?
		`COUNT_BITS'(`LINE_VERTICES) : remaining[`COUNT_BITS-1:0];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:       if (chunk_ready) next_state = SIZE;
			SIZE:       next_state = SEND_IN;
			SEND_IN:    next_state = SEND_OUT;
			SEND_OUT:   next_state = SEND_EDGES;
			SEND_EDGES: next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	// bases only change on start
	always_ff @(posedge clock) begin
		if (start) begin
			in_base    <= in_degree_base;
			out_base   <= out_degree_base;
			edges_base <= edges_idx_base;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			offset    <= '0;
			real_size <= '0;
		end else if (start) begin
			remaining <= num_vertices;
			offset    <= '0;
		end else begin
			if (state == SIZE) begin
				real_size <= chunk_size;
				remaining <= remaining - `VERTEX_BITS'(chunk_size);
			end
			if (state == SEND_EDGES)
				offset <= offset + `ADDR_BITS'(`LINE_BYTES);  // next line
		end
	end

	//////////////////////////////
	// command outputs
	//////////////////////////////
	assign cmd_valid = (state == SEND_IN) || (state == SEND_OUT) || (state == SEND_EDGES);
	assign cmd_size  = {real_size, 2'b00};   // four bytes per vertex word

	always_comb begin
		cmd_tag.real_size = real_size;
		cmd_tag.array     = vertex_job_pkg::IN_DEGREE;
		cmd_addr          = '0;
		case (state)
			SEND_IN: begin
				cmd_addr = in_base + offset;
			end
			SEND_OUT: begin
				cmd_tag.array = vertex_job_pkg::OUT_DEGREE;
				cmd_addr      = out_base + offset;
			end
			SEND_EDGES: begin
				cmd_tag.array = vertex_job_pkg::EDGES_IDX;
				cmd_addr      = edges_base + offset;
			end
			default: ;
		endcase
	end

	// issue and response may land in the same cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else begin
			case ({cmd_valid, resp_valid})
				2'b10:   outstanding <= outstanding + 3'd1;
				2'b01:   outstanding <= outstanding - 3'd1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// memory must never answer a read that was not issued
	a_resp_has_read: assert property (@(posedge clock) disable iff (!rstn)
		resp_valid |-> (outstanding != '0));

endmodule

// ==== vertex_fetch/cacheline_stream.sv ====
`timescale 1ns/1ps
`include "vertex_job_consts.svh"

module cacheline_stream #(
	parameter vertex_job_pkg::vertex_array_t ARRAY = vertex_job_pkg::IN_DEGREE
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        resp_valid,
	input  vertex_job_pkg::read_tag_t   resp_tag,
	input  vertex_job_pkg::cacheline_t  resp_data,
	input  logic                        shift,
	output logic [`VERTEX_BITS-1:0]     word,
	output logic                        ready
);

	vertex_job_pkg::cacheline_t line;
	logic [`COUNT_BITS-1:0]     limit;      // real size of the held line
	logic [`COUNT_BITS-1:0]     shifts;
	logic                       match;

	assign match = resp_valid && (resp_tag.array == ARRAY);
	assign word  = line.words[0];   // lowest remaining vertex

	always_ff @(posedge clock) begin
		if (match) begin
			line  <= resp_data;
			limit <= resp_tag.real_size;
		end else if (shift) begin
			line.raw <= line.raw >> `VERTEX_BITS;   // next word moves down
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready  <= 1'b0;
			shifts <= '0;
		end else if (match) begin
			ready  <= 1'b1;
			shifts <= '0;
		end else if (shift) begin
			shifts <= shifts + 1'b1;
			if (shifts + 1'b1 == limit)
				ready <= 1'b0;    // line drained
		end
	end

	a_shift_when_ready: assert property (@(posedge clock) disable iff (!rstn)
		shift |-> ready);

	// a new line for this array only comes once the old one is drained
	a_no_overwrite: assert property (@(posedge clock) disable iff (!rstn)
		match |-> !ready);

endmodule

// ==== design/vertex_assembler.sv ====
`timescale 1ns/1ps
`include "vertex_job_consts.svh"

module vertex_assembler (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic [`VERTEX_BITS-1:0]     in_word,
	input  logic [`VERTEX_BITS-1:0]     out_word,
	input  logic [`VERTEX_BITS-1:0]     edges_word,
	input  logic                        in_ready,
	input  logic                        out_ready,
	input  logic                        edges_ready,
	output logic                        shift,
	output logic                        push,
	output logic                        assembler_busy,
	output vertex_job_pkg::vertex_job_t job
);

	logic [`VERTEX_BITS-1:0]    next_id;
	logic                       job_pending;

	// all three lines must hold the same vertex
	assign shift = in_ready && out_ready && edges_ready;

	always_ff @(posedge clock) begin
		if (shift) begin
			job.id         <= next_id;
			job.in_degree  <= in_word;
			job.out_degree <= out_word;
			job.edges_idx  <= edges_word;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_id     <= '0;
			job_pending <= 1'b0;
		end else begin
			job_pending <= shift;
			if (shift)
				next_id <= next_id + 1'b1;   // dropped vertices still take an id
		end
	end

	//////////////////////////////
	// filter and status
	//////////////////////////////
	// isolated vertices have no work
	assign push = job_pending && ((job.in_degree != '0) || (job.out_degree != '0));

	assign assembler_busy = in_ready || out_ready || edges_ready || job_pending;

endmodule

// ==== design/job_fifo.sv ====
`timescale 1ns/1ps
`include "vertex_job_consts.svh"

module job_fifo #(
	parameter int DEPTH = `JOB_FIFO_DEPTH
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        push,
	input  logic                        pop,
	input  vertex_job_pkg::vertex_job_t data_in,
	output vertex_job_pkg::vertex_job_t data_out,
	output logic                        valid,
	output logic                        almost_full
);

	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	vertex_job_pkg::vertex_job_t    mem [DEPTH];
	logic [PTR_BITS-1:0]            wr_ptr, rd_ptr;
	logic [CNT_BITS-1:0]            count;

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign data_out = mem[rd_ptr];  // head shown without a read cycle
	assign valid    = (count != '0);

	// less than a whole line of space left
	assign almost_full = (count > CNT_BITS'(DEPTH - `LINE_VERTICES));

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		push |-> (count != CNT_BITS'(DEPTH)) || pop);

	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> valid);

endmodule

// ==== design/vertex_job_control.sv ====
`timescale 1ns/1ps
`include "vertex_job_consts.svh"

module vertex_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        start,
	input  logic [`VERTEX_BITS-1:0]     num_vertices,
	input  logic [`ADDR_BITS-1:0]       in_degree_base,
	input  logic [`ADDR_BITS-1:0]       out_degree_base,
	input  logic [`ADDR_BITS-1:0]       edges_idx_base,
	output logic                        cmd_valid,
	output logic [`ADDR_BITS-1:0]       cmd_addr,
	output logic [`COUNT_BITS+1:0]      cmd_size,
	output vertex_job_pkg::read_tag_t   cmd_tag,
	input  logic                        resp_valid,
	input  vertex_job_pkg::read_tag_t   resp_tag,
	input  vertex_job_pkg::cacheline_t  resp_data,
	input  logic                        job_pop,
	output logic                        job_valid,
	output vertex_job_pkg::vertex_job_t job_data
);

	logic [`VERTEX_BITS-1:0]        in_word, out_word, edges_word;
	logic                           in_ready, out_ready, edges_ready;
	logic                           shift, push, assembler_busy, almost_full;
	vertex_job_pkg::vertex_job_t    job;

	//////////////////////////////
	// fetch
	//////////////////////////////
	read_command_gen u_cmd_gen (
		.clock(clock), .rstn(rstn), .start(start), .num_vertices(num_vertices),
		.in_degree_base(in_degree_base), .out_degree_base(out_degree_base),
		.edges_idx_base(edges_idx_base), .resp_valid(resp_valid),
		.assembler_busy(assembler_busy), .almost_full(almost_full),
		.cmd_valid(cmd_valid), .cmd_addr(cmd_addr), .cmd_size(cmd_size), .cmd_tag(cmd_tag)
	);

	// one stream per array, all watching the same response bus
	cacheline_stream #(.ARRAY(vertex_job_pkg::IN_DEGREE)) u_in_stream (
		.clock(clock), .rstn(rstn), .resp_valid(resp_valid), .resp_tag(resp_tag),
		.resp_data(resp_data), .shift(shift), .word(in_word), .ready(in_ready)
	);

	cacheline_stream #(.ARRAY(vertex_job_pkg::OUT_DEGREE)) u_out_stream (
		.clock(clock), .rstn(rstn), .resp_valid(resp_valid), .resp_tag(resp_tag),
		.resp_data(resp_data), .shift(shift), .word(out_word), .ready(out_ready)
	);

	cacheline_stream #(.ARRAY(vertex_job_pkg::EDGES_IDX)) u_edges_stream (
		.clock(clock), .rstn(rstn), .resp_valid(resp_valid), .resp_tag(resp_tag),
		.resp_data(resp_data), .shift(shift), .word(edges_word), .ready(edges_ready)
	);

	//////////////////////////////
	// assembly and queue
	//////////////////////////////
	vertex_assembler u_assembler (
		.clock(clock), .rstn(rstn), .in_word(in_word), .out_word(out_word),
		.edges_word(edges_word), .in_ready(in_ready), .out_ready(out_ready),
		.edges_ready(edges_ready), .shift(shift), .push(push),
		.assembler_busy(assembler_busy), .job(job)
	);

	job_fifo #(.DEPTH(`JOB_FIFO_DEPTH)) u_job_fifo (
		.clock(clock), .rstn(rstn), .push(push), .pop(job_pop), .data_in(job),
		.data_out(job_data), .valid(job_valid), .almost_full(almost_full)
	);

endmodule

// ==== bench/tb_vertex_job_control.sv ====
`timescale 1ns/1ps
`include "vertex_job_consts.svh"

module tb_vertex_job_control;

	localparam int N_PARTIAL = 3;
	localparam int N_MULTI   = 10;
	localparam int N_REORDER = 9;
	localparam int N_STALL   = 16;
	localparam int TIMEOUT_CYCLES = 40 * (N_PARTIAL + N_MULTI + N_REORDER + N_STALL) + 200;
	localparam int MAX_HELD  = `JOB_FIFO_DEPTH - `LINE_VERTICES;

	logic                           clock = 1'b0;
	logic                           rstn;
	logic                           start;
	logic [`VERTEX_BITS-1:0]        num_vertices;
	logic [`ADDR_BITS-1:0]          in_degree_base, out_degree_base, edges_idx_base;
	logic                           cmd_valid;
	logic [`ADDR_BITS-1:0]          cmd_addr;
	logic [`COUNT_BITS+1:0]         cmd_size;
	vertex_job_pkg::read_tag_t      cmd_tag;
	logic                           resp_valid = 1'b0;
	vertex_job_pkg::read_tag_t      resp_tag = '0;
	vertex_job_pkg::cacheline_t     resp_data = '0;
	logic                           job_pop = 1'b0;
	logic                           job_valid;
	vertex_job_pkg::vertex_job_t    job_data;

	string                          test_name = "init";
	int                             cyc = 0;
	int                             n_vertices = 0;
	int                             chunks_total = 0;
	int                             cmd_count = 0;
	int                             popped_count = 0;
	int                             last_activity = 0;
	bit                             reverse_order = 1'b0;
	bit                             pop_enable = 1'b0;
	logic [31:0]                    lfsr_state = 32'ha646_8a40;
	logic [`VERTEX_BITS-1:0]        in_mem [32];
	logic [`VERTEX_BITS-1:0]        out_mem [32];
	logic [`VERTEX_BITS-1:0]        edges_mem [32];
	vertex_job_pkg::vertex_job_t    exp_q [$];
	vertex_job_pkg::read_tag_t      pend_tag [$];    // reads waiting for their line
	int                             pend_chunk [$];
	int                             pend_due [$];
	logic [`ADDR_BITS-1:0]          pend_addr [$];

	vertex_job_control UUT (.*);

	always #4 clock = ~clock;

	//////////////////////////////
	// failure reporting
	//////////////////////////////
	task automatic report_mismatch(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	always @(posedge clock) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	//////////////////////////////
	// stimulus data and reference
	//////////////////////////////
	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [`VERTEX_BITS-1:0] mem_word(input vertex_job_pkg::vertex_array_t arr,
			input int v);
		case (arr)
			vertex_job_pkg::IN_DEGREE:  return in_mem[v];
			vertex_job_pkg::OUT_DEGREE: return out_mem[v];
			default:                    return edges_mem[v];
		endcase
	endfunction

	function automatic logic [`ADDR_BITS-1:0] base_of(input int arr);
		case (arr)
			0:       return in_degree_base;
			1:       return out_degree_base;
			default: return edges_idx_base;
		endcase
	endfunction

	// jobs the queue has taken in from vertices below limit
	function automatic int kept_below(input int limit);
		int kept;
		kept = 0;
		for (int v = 0; v < limit && v < n_vertices; v++)
			if (in_mem[v] != '0 || out_mem[v] != '0)
				kept++;
		return kept;
	endfunction

	task automatic fill_memory();
		vertex_job_pkg::vertex_job_t job;
		exp_q.delete();
		for (int v = 0; v < n_vertices; v++) begin
			in_mem[v]    = take_bits(32);
			out_mem[v]   = take_bits(32);
			edges_mem[v] = take_bits(32);
			if (v % 3 == 0) begin   // isolated vertex
				in_mem[v]  = '0;
				out_mem[v] = '0;
			end
			job.id         = `VERTEX_BITS'(v);
			job.in_degree  = in_mem[v];
			job.out_degree = out_mem[v];
			job.edges_idx  = edges_mem[v];
			if (in_mem[v] != '0 || out_mem[v] != '0)
				exp_q.push_back(job);
		end
	endtask

	//////////////////////////////
	// memory responder and consumer
	//////////////////////////////
	task automatic check_command();
		int                    chunk;
		int                    arr;
		int                    size;
		logic [`ADDR_BITS-1:0] addr;
		chunk = cmd_count / 3;
		arr   = cmd_count % 3;    // in, out, edges
		size  = n_vertices - chunk * `LINE_VERTICES;
		if (size > `LINE_VERTICES)
			size = `LINE_VERTICES;
		addr = base_of(arr) + `ADDR_BITS'(chunk * `LINE_BYTES);
		assert (chunk < chunks_total) else report_failure("command issued past the last chunk");
		assert (cmd_addr == addr) else report_mismatch("cmd_addr", 128'(addr), 128'(cmd_addr));
		assert (cmd_tag.array == vertex_job_pkg::vertex_array_t'(arr))
			else report_mismatch("cmd_tag.array", 128'(arr), 128'(cmd_tag.array));
		assert (cmd_tag.real_size == `COUNT_BITS'(size))
			else report_mismatch("cmd_tag.real_size", 128'(size), 128'(cmd_tag.real_size));
		assert (cmd_size == 6'(size * 4))
			else report_mismatch("cmd_size", 128'(size * 4), 128'(cmd_size));
		if (arr == 0)
			assert (kept_below(chunk * `LINE_VERTICES) - popped_count <= MAX_HELD)
				else report_failure("command issued while the job queue lacked room for a line");
		pend_tag.push_back(cmd_tag);
		pend_chunk.push_back(chunk);
		pend_addr.push_back(cmd_addr);
		pend_due.push_back(cyc + 1 + int'(take_bits(3) % 6));
		cmd_count++;
		last_activity = cyc;
	endtask

	function automatic int pick_response();
		if (pend_tag.size() == 0)
			return -1;
		if (reverse_order) begin
			// newest first, once the whole chunk is out
			if (cmd_count % 3 == 0 && pend_due[pend_due.size() - 1] <= cyc)
				return pend_due.size() - 1;
			return -1;
		end
		for (int i = 0; i < pend_due.size(); i++)
			if (pend_due[i] <= cyc)
				return i;
		return -1;
	endfunction

	task automatic send_response(input int idx);
		vertex_job_pkg::cacheline_t line;
		int                         v;
		for (int i = 0; i < `LINE_VERTICES; i++) begin
			v = pend_chunk[idx] * `LINE_VERTICES + i;
			if (v < n_vertices)
				line.words[i] = mem_word(pend_tag[idx].array, v);
			else
				line.words[i] = pend_addr[idx][31:0] ^ pend_addr[idx][63:32] ^ 32'(i);
		end
		resp_tag   = pend_tag[idx];
		resp_data  = line;
		resp_valid = 1'b1;
		pend_tag.delete(idx);
		pend_chunk.delete(idx);
		pend_addr.delete(idx);
		pend_due.delete(idx);
		last_activity = cyc;
	endtask

	task automatic take_job();
		assert (exp_q.size() != 0) else report_failure("job appeared with none left to expect");
		assert (job_data == exp_q[0]) else report_mismatch("job", exp_q[0], job_data);
		exp_q.pop_front();
		popped_count++;
		job_pop = 1'b1;
	endtask

	always @(negedge clock) begin
		int idx;
		resp_valid = 1'b0;
		job_pop    = 1'b0;
		if (rstn) begin
			if (cmd_valid)
				check_command();
			idx = pick_response();
			if (idx >= 0)
				send_response(idx);
			if (pop_enable && job_valid)
				take_job();
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic apply_reset();
		@(negedge clock);
		rstn  = 1'b0;
		start = 1'b0;
		pend_tag.delete();
		pend_chunk.delete();
		pend_addr.delete();
		pend_due.delete();
		cmd_count     = 0;
		popped_count  = 0;
		last_activity = cyc;
		repeat (5) begin
			@(negedge clock);
			assert (!cmd_valid && !job_valid) else report_failure("outputs high during reset");
		end
		rstn = 1'b1;
	endtask

	task automatic run_job(input string name, input int n, input bit reverse, input bit hold);
		test_name = name;
		apply_reset();
		n_vertices    = n;
		chunks_total  = (n + `LINE_VERTICES - 1) / `LINE_VERTICES;
		reverse_order = reverse;
		pop_enable    = !hold;
		fill_memory();
		@(negedge clock);
		start           = 1'b1;
		num_vertices    = `VERTEX_BITS'(n);
		in_degree_base  = 64'h0000_0001_0000_0000 + 64'(n) * 64'h100;
		out_degree_base = 64'h0000_0002_0000_1000 + 64'(n) * 64'h100;
		edges_idx_base  = 64'h0000_0003_0000_2000 + 64'(n) * 64'h100;
		@(negedge clock);
		start = 1'b0;
		if (hold) begin   // let the queue fill up
			@(posedge clock);
			while (cyc - last_activity < 20)
				@(posedge clock);
			assert (job_valid && cmd_count < 3 * chunks_total)
				else report_failure("command issue did not stall with no pops");
			pop_enable = 1'b1;
		end
		@(posedge clock);
		while (exp_q.size() != 0 || cmd_count != 3 * chunks_total || pend_tag.size() != 0)
			@(posedge clock);
		repeat (10) @(posedge clock);   // stray jobs or commands show up in the monitor
	endtask

	task automatic test_reset();
		test_name = "reset";
		apply_reset();
		repeat (5) begin
			@(negedge clock);
			assert (!cmd_valid && !job_valid) else report_failure("outputs high after reset");
		end
	endtask

	task automatic test_partial_line();
		run_job("partial_line", N_PARTIAL, 1'b0, 1'b0);
	endtask

	task automatic test_multi_chunk();
		run_job("multi_chunk", N_MULTI, 1'b0, 1'b0);
	endtask

	task automatic test_out_of_order();
		run_job("out_of_order", N_REORDER, 1'b1, 1'b0);
	endtask

	task automatic test_back_pressure();
		run_job("back_pressure", N_STALL, 1'b0, 1'b1);
	endtask

	initial begin
		rstn            = 1'b0;
		start           = 1'b0;
		num_vertices    = '0;
		in_degree_base  = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		test_reset();
		test_partial_line();
		test_multi_chunk();
		test_out_of_order();
		test_back_pressure();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+common
common/vertex_job_pkg.sv
vertex_fetch/read_command_gen.sv
vertex_fetch/cacheline_stream.sv
design/vertex_assembler.sv
design/job_fifo.sv
design/vertex_job_control.sv
bench/tb_vertex_job_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vertex_job_control
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f project.f

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
